//--- project.f
+incdir+hw
hw/sdram_stats_pkg.sv
hw/sdram_cmd_decode.sv
hw/sdram_bank_stats.sv
hw/sdram_stats_readout.sv
hw/sdram_stats_top.sv
verification/sdram_stats_tb.sv

//--- Makefile
# Verilator build and run for the SDRAM statistics monitor

VERILATOR := verilator
VFLAGS    := --binary --timing --assert -Wno-fatal
TOP       := sdram_stats_tb
FILELIST  := project.f
BUILD_DIR := obj_dir
LOG       := sim.log
PASS_MSG  := Done: no errors

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(BUILD_DIR) -o $(TOP)
	./$(BUILD_DIR)/$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) || { echo "Simulation failed, see $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- verification/sdram_stats_stimulus.txt
# C cs_n,ras_n,cas_n,we_n(bin) bank addr(hex) | K clear pulse
# R test bank field expected(dec) | S test expected, all banks and fields
# Activations with refresh and precharge mixed in
C 0011 0 0000
C 0001 0 0000
C 0011 1 0020
C 0011 0 0011
C 0010 0 0400
C 0011 3 0030
C 1011 1 0020
C 0011 1 0021
C 0011 1 0020
C 0001 0 0000
C 0011 3 0030
R act_b0 0 0 2
R act_b1 1 0 3
R act_b2 2 0 0
R act_b3 3 0 2
R samerow_b0_first 0 1 0
R samerow_b3 3 1 1
R longest_b3 3 2 2
# Same-row runs on bank 2, rows 5 5 5 9 9 5
C 0011 2 0005
C 0011 2 0005
C 0011 0 0012
C 0011 2 0005
C 0011 2 0009
C 0011 2 0009
C 0011 2 0005
R act_b2_runs 2 0 6
R samerow_b2 2 1 3
R longest_b2 2 2 3
R samerow_b1 1 1 0
R longest_b1 1 2 1
# Reads and writes, A10 is auto-precharge
C 0101 0 0004
C 0101 0 0408
C 0100 1 0010
C 0100 1 0410
C 0100 1 0020
C 0101 3 0400
C 1101 3 0400
C 1100 2 0410
C 0100 2 1c00
C 0101 2 0003
C 0111 2 0400
C 0010 1 0400
R read_b0 0 3 2
R write_b0 0 4 0
R autopre_b0 0 5 1
R read_b1 1 3 0
R write_b1 1 4 3
R autopre_b1 1 5 1
R read_b2 2 3 1
R write_b2 2 4 1
R autopre_b2 2 5 1
R read_b3 3 3 1
R write_b3 3 4 0
R autopre_b3 3 5 1
# Total over all banks and the unassigned field
R total 1 6 14
R undefined_field 2 7 0
# Clear, then counting and row matching restart
K
S cleared 0
C 0011 3 0030
R act_b3_after_clr 3 0 1
R samerow_b3_after_clr 3 1 0
C 0011 3 0030
R samerow_b3_again 3 1 1
R longest_b3_again 3 2 2
R total_after_clr 0 6 2

//--- verification/sdram_stats_tb.sv
// SDRAM statistics monitor testbench
`include "sdram_stats_defines.svh"

module sdram_stats_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam string STIM_FILE = "verification/sdram_stats_stimulus.txt";

    logic                    clk;
    logic                    rst;
    logic [`SDRAM_AW-1:0]    sdram_a;
    logic [`SDRAM_BAW-1:0]   sdram_ba;
    logic                    sdram_ncs;
    logic                    sdram_nras;
    logic                    sdram_ncas;
    logic                    sdram_nwe;
    logic                    clr;
    logic [`SDRAM_BAW-1:0]   stat_bank;
    logic [`FLD_W-1:0]       stat_field;
    sdram_stats_pkg::stat_t  stat_data;

    int tests        = 0;
    int fails        = 0;   // Value mismatches
    int other_errors = 0;   // Unreadable stimulus lines
    int cycle_cnt    = 0;
    int cycle_limit  = 0;
    bit limit_set    = 1'b0;

    sdram_stats_top sdram_stats_top_inst (
        .clk        (clk),
        .rst        (rst),
        .sdram_a    (sdram_a),
        .sdram_ba   (sdram_ba),
        .sdram_ncs  (sdram_ncs),
        .sdram_nras (sdram_nras),
        .sdram_ncas (sdram_ncas),
        .sdram_nwe  (sdram_nwe),
        .clr        (clr),
        .stat_bank  (stat_bank),
        .stat_field (stat_field),
        .stat_data  (stat_data)
    );

    // 20 ns clock
    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
    end

    // Watchdog with a limit from the stimulus length
    initial begin
        wait (limit_set);
        while (cycle_cnt < cycle_limit) begin
            @(posedge clk);
        end
        $display("Timeout: stimulus did not finish within %0d cycles", cycle_limit);
        $display("Done: errors found");
        $finish;
    end

    task automatic check_value(input string name, input sdram_stats_pkg::stat_t expected,
                               input sdram_stats_pkg::stat_t actual);
        tests++;
        if (actual !== expected) begin
            fails++;
            $display("ERROR %s: expected %0d, actual %0d", name, expected, actual);
        end else begin
            $display("ok    %s = %0d", name, actual);
        end
    endtask

    // One command per cycle held for exactly one edge
    task automatic drive_command(input logic [3:0] pins, input logic [`SDRAM_BAW-1:0] ba,
                                 input logic [`SDRAM_AW-1:0] a);
        @(posedge clk);
        {sdram_ncs, sdram_nras, sdram_ncas, sdram_nwe} <= pins;
        sdram_ba <= ba;
        sdram_a  <= a;
    endtask

    task automatic read_stat(input logic [`SDRAM_BAW-1:0] bank, input logic [`FLD_W-1:0] field,
                             output sdram_stats_pkg::stat_t value);
        @(posedge clk);
        sdram_ncs  <= 1'b1;  // Deselect so the last command is not repeated
        stat_bank  <= bank;
        stat_field <= field;
        repeat (4) @(posedge clk);  // Decode, count and readout latencies
        @(negedge clk);
        value = stat_data;
    endtask

    task automatic pulse_clear();
        @(posedge clk);
        sdram_ncs <= 1'b1;
        repeat (3) @(posedge clk);  // Commands in flight land first
        clr <= 1'b1;
        @(posedge clk);
        clr <= 1'b0;
    endtask

    // Every field of every bank including the total
    task automatic sweep_all(input string name, input sdram_stats_pkg::stat_t expected);
        logic [`SDRAM_BAW-1:0]   bank_sel;
        logic [`FLD_W-1:0]       field_sel;
        sdram_stats_pkg::stat_t  value;
        for (int b = 0; b < `SDRAM_BANKS; b++) begin
            for (int f = 0; f <= 6; f++) begin
                bank_sel  = b[`SDRAM_BAW-1:0];
                field_sel = f[`FLD_W-1:0];
                read_stat(bank_sel, field_sel, value);
                check_value($sformatf("%0s_b%0d_f%0d", name, b, f), expected, value);
            end
        end
    endtask

    task automatic count_lines(output int n, output bit ok);
        int               fd;
        int               r;
        logic [8*256-1:0] line;
        n  = 0;
        fd = $fopen(STIM_FILE, "r");
        ok = (fd != 0);
        if (ok) begin
            while (!$feof(fd)) begin
                r = $fgets(line, fd);
                if (r > 0) begin
                    n++;
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic run_stimulus();
        int                      fd;
        int                      r;
        bit                      done;
        bit                      bad;
        logic [7:0]              kind;     // First character picks the line kind
        logic [3:0]              pins;
        int                      bank;
        int                      field;
        logic [`SDRAM_AW-1:0]    addr;
        logic [8*32-1:0]         name;
        logic [8*256-1:0]        rest;
        sdram_stats_pkg::stat_t  expected;
        sdram_stats_pkg::stat_t  value;
        fd   = $fopen(STIM_FILE, "r");
        done = 1'b0;
        while (!done) begin
            r = $fscanf(fd, " %c", kind);
            if (r != 1) begin
                done = 1'b1;  // End of file
            end else begin
                bad = 1'b0;
                case (kind)
                    "#": begin
                        r = $fgets(rest, fd);  // Skip comment text
                    end
                    "C": begin
                        if ($fscanf(fd, "%b %d %h", pins, bank, addr) == 3) begin
                            drive_command(pins, bank[`SDRAM_BAW-1:0], addr);
                        end else begin
                            bad = 1'b1;
                        end
                    end
                    "K": begin
                        pulse_clear();
                    end
                    "R": begin
                        if ($fscanf(fd, "%s %d %d %d", name, bank, field, expected) == 4) begin
                            read_stat(bank[`SDRAM_BAW-1:0], field[`FLD_W-1:0], value);
                            check_value($sformatf("%0s", name), expected, value);
                        end else begin
                            bad = 1'b1;
                        end
                    end
                    "S": begin
                        if ($fscanf(fd, "%s %d", name, expected) == 2) begin
                            sweep_all($sformatf("%0s", name), expected);
                        end else begin
                            bad = 1'b1;
                        end
                    end
                    default: begin
                        bad = 1'b1;
                    end
                endcase
                if (bad) begin
                    other_errors++;
                    $display("Stimulus line of kind '%c' could not be read", kind);
                    done = 1'b1;
                end
            end
        end
        $fclose(fd);
    endtask

    initial begin
        int n_lines;
        bit open_ok;
        rst        = 1'b1;
        clr        = 1'b0;
        sdram_ncs  = 1'b1;  // Bus idle and deselected
        sdram_nras = 1'b1;
        sdram_ncas = 1'b1;
        sdram_nwe  = 1'b1;
        sdram_ba   = '0;
        sdram_a    = '0;
        stat_bank  = '0;
        stat_field = '0;
        count_lines(n_lines, open_ok);
        cycle_limit = 8 * n_lines + 200;
        limit_set   = 1'b1;
        if (!open_ok) begin
            $display("Cannot open the stimulus file %s", STIM_FILE);
            $display("Done: errors found");
            $finish;
        end else begin
            repeat (2) @(posedge clk);
            rst <= 1'b0;
            run_stimulus();
            $display("Tests %0d, passed %0d, failed %0d, other errors %0d",
                     tests, tests - fails, fails, other_errors);
            if (fails == 0 && other_errors == 0) begin
                $display("Done: no errors");
            end else begin
                $display("Done: errors found");
            end
            $finish;
        end
    end

endmodule

//--- hw/sdram_stats_top.sv
// SDRAM statistics monitor top
`include "sdram_stats_defines.svh"

module sdram_stats_top (
    input  logic                    clk,
    input  logic                    rst,
    // Sampled SDRAM pins that are never driven
    input  logic [`SDRAM_AW-1:0]    sdram_a,
    input  logic [`SDRAM_BAW-1:0]   sdram_ba,
    input  logic                    sdram_ncs,
    input  logic                    sdram_nras,
    input  logic                    sdram_ncas,
    input  logic                    sdram_nwe,
    // Host side
    input  logic                    clr,         // Pulse that zeroes all counters
    input  logic [`SDRAM_BAW-1:0]   stat_bank,
    input  logic [`FLD_W-1:0]       stat_field,
    output sdram_stats_pkg::stat_t  stat_data
);

    logic                          ev_act;
    logic                          ev_read;
    logic                          ev_write;
    logic [`SDRAM_BAW-1:0]         ev_ba;
    sdram_stats_pkg::sdram_addr_u  ev_addr;

    // Per-bank counters indexed by bank address
    sdram_stats_pkg::stat_t act_cnt     [`SDRAM_BANKS];
    sdram_stats_pkg::stat_t samerow_cnt [`SDRAM_BANKS];
    sdram_stats_pkg::stat_t longest_run [`SDRAM_BANKS];
    sdram_stats_pkg::stat_t read_cnt    [`SDRAM_BANKS];
    sdram_stats_pkg::stat_t write_cnt   [`SDRAM_BANKS];
    sdram_stats_pkg::stat_t autopre_cnt [`SDRAM_BANKS];

    sdram_cmd_decode sdram_cmd_decode_inst (
        .clk        (clk),
        .rst        (rst),
        .sdram_a    (sdram_a),
        .sdram_ba   (sdram_ba),
        .sdram_ncs  (sdram_ncs),
        .sdram_nras (sdram_nras),
        .sdram_ncas (sdram_ncas),
        .sdram_nwe  (sdram_nwe),
        .ev_act     (ev_act),
        .ev_read    (ev_read),
        .ev_write   (ev_write),
        .ev_ba      (ev_ba),
        .ev_addr    (ev_addr)
    );

    // Every bank sees every event and filters on its own address
    for (genvar b = 0; b < `SDRAM_BANKS; b++) begin : g_bank
        sdram_bank_stats #(
            .BANK (b)
        ) sdram_bank_stats_inst (
            .clk         (clk),
            .rst         (rst),
            .clr         (clr),
            .ev_act      (ev_act),
            .ev_read     (ev_read),
            .ev_write    (ev_write),
            .ev_ba       (ev_ba),
            .ev_addr     (ev_addr),
            .act_cnt     (act_cnt[b]),
            .samerow_cnt (samerow_cnt[b]),
            .longest_run (longest_run[b]),
            .read_cnt    (read_cnt[b]),
            .write_cnt   (write_cnt[b]),
            .autopre_cnt (autopre_cnt[b])
        );
    end

    sdram_stats_readout sdram_stats_readout_inst (
        .clk         (clk),
        .rst         (rst),
        .stat_bank   (stat_bank),
        .stat_field  (stat_field),
        .act_cnt     (act_cnt),
        .samerow_cnt (samerow_cnt),
        .longest_run (longest_run),
        .read_cnt    (read_cnt),
        .write_cnt   (write_cnt),
        .autopre_cnt (autopre_cnt),
        .stat_data   (stat_data)
    );

endmodule

//--- hw/sdram_stats_readout.sv
// SDRAM statistics readout selector
`include "sdram_stats_defines.svh"

module sdram_stats_readout (
    input  logic                    clk,
    input  logic                    rst,
    input  logic [`SDRAM_BAW-1:0]   stat_bank,
    input  logic [`FLD_W-1:0]       stat_field,
    input  sdram_stats_pkg::stat_t  act_cnt     [`SDRAM_BANKS],
    input  sdram_stats_pkg::stat_t  samerow_cnt [`SDRAM_BANKS],
    input  sdram_stats_pkg::stat_t  longest_run [`SDRAM_BANKS],
    input  sdram_stats_pkg::stat_t  read_cnt    [`SDRAM_BANKS],
    input  sdram_stats_pkg::stat_t  write_cnt   [`SDRAM_BANKS],
    input  sdram_stats_pkg::stat_t  autopre_cnt [`SDRAM_BANKS],
    output sdram_stats_pkg::stat_t  stat_data
);

    logic [`STAT_W+1:0]      total_sum;  // Two guard bits for four banks
    sdram_stats_pkg::stat_t  total_sat;
    sdram_stats_pkg::stat_t  sel_value;

    // Activations over all banks
    always_comb begin
        total_sum = '0;
        for (int b = 0; b < `SDRAM_BANKS; b++) begin
            total_sum = total_sum + {2'b00, act_cnt[b]};
        end
    end

    // Same saturation rule as the counters
    assign total_sat = (|total_sum[`STAT_W+1:`STAT_W]) ? '1 : total_sum[`STAT_W-1:0];

    always_comb begin
        case (stat_field)
            `FLD_ACT:     sel_value = act_cnt[stat_bank];
            `FLD_SAMEROW: sel_value = samerow_cnt[stat_bank];
            `FLD_LONGEST: sel_value = longest_run[stat_bank];
            `FLD_READ:    sel_value = read_cnt[stat_bank];
            `FLD_WRITE:   sel_value = write_cnt[stat_bank];
            `FLD_AUTOPRE: sel_value = autopre_cnt[stat_bank];
            `FLD_TOTAL:   sel_value = total_sat;   // Bank select ignored
            default:      sel_value = '0;          // Unassigned code
        endcase
    end

    // One cycle from selection to data
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            stat_data <= '0;
        end else begin
            stat_data <= sel_value;
        end
    end

endmodule

//--- hw/sdram_bank_stats.sv
// SDRAM per-bank statistics
`include "sdram_stats_defines.svh"

module sdram_bank_stats #(
    parameter int BANK = 0  // Bank address this instance owns
) (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          clr,       // Zero all counters
    input  logic                          ev_act,
    input  logic                          ev_read,
    input  logic                          ev_write,
    input  logic [`SDRAM_BAW-1:0]         ev_ba,
    input  sdram_stats_pkg::sdram_addr_u  ev_addr,
    output sdram_stats_pkg::stat_t        act_cnt,
    output sdram_stats_pkg::stat_t        samerow_cnt,
    output sdram_stats_pkg::stat_t        longest_run,
    output sdram_stats_pkg::stat_t        read_cnt,
    output sdram_stats_pkg::stat_t        write_cnt,
    output sdram_stats_pkg::stat_t        autopre_cnt
);

    if (BANK < 0 || BANK >= `SDRAM_BANKS) begin : g_bad_bank
        $error("sdram_bank_stats: BANK out of range");
    end

    localparam logic [`SDRAM_BAW-1:0] BANK_ID = BANK[`SDRAM_BAW-1:0];

    logic                    own_act;
    logic                    own_read;
    logic                    own_write;
    logic                    row_hit;
    logic                    row_valid;   // last_row holds a real row
    logic [`SDRAM_AW-1:0]    last_row;
    sdram_stats_pkg::stat_t  cur_run;     // Same-row run in progress
    sdram_stats_pkg::stat_t  next_run;

    // Counters stick at all-ones
    function automatic sdram_stats_pkg::stat_t sat_inc(input sdram_stats_pkg::stat_t v);
        sat_inc = (&v) ? v : v + 1'b1;
    endfunction

    assign own_act   = ev_act   && (ev_ba == BANK_ID);
    assign own_read  = ev_read  && (ev_ba == BANK_ID);
    assign own_write = ev_write && (ev_ba == BANK_ID);

    // First activation after reset or clear never hits
    assign row_hit  = row_valid && (ev_addr.row == last_row);
    assign next_run = row_hit ? sat_inc(cur_run) : sdram_stats_pkg::stat_t'(1);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            act_cnt     <= '0;
            samerow_cnt <= '0;
            longest_run <= '0;
            read_cnt    <= '0;
            write_cnt   <= '0;
            autopre_cnt <= '0;
            cur_run     <= '0;
            row_valid   <= 1'b0;
        end else if (clr) begin
            act_cnt     <= '0;
            samerow_cnt <= '0;
            longest_run <= '0;
            read_cnt    <= '0;
            write_cnt   <= '0;
            autopre_cnt <= '0;
            cur_run     <= '0;
            row_valid   <= 1'b0;  // Row matching restarts
        end else begin
            if (own_act) begin
                act_cnt   <= sat_inc(act_cnt);
                cur_run   <= next_run;
                row_valid <= 1'b1;
                if (row_hit) begin
                    samerow_cnt <= sat_inc(samerow_cnt);
                end
                // Includes the activation just seen
                if (next_run > longest_run) begin
                    longest_run <= next_run;
                end
            end
            if (own_read) begin
                read_cnt <= sat_inc(read_cnt);
            end
            if (own_write) begin
                write_cnt <= sat_inc(write_cnt);
            end
            if ((own_read || own_write) && ev_addr.col.ap) begin
                autopre_cnt <= sat_inc(autopre_cnt);  // A10 closes the row
            end
        end
    end

    // Row only reloaded on a miss
    always_ff @(posedge clk) begin
        if (own_act && !row_hit) begin
            last_row <= ev_addr.row;
        end
    end

    samerow_bound: assert property (@(posedge clk) disable iff (rst)
        samerow_cnt <= act_cnt)
        else $error("bank %0d: same-row hits exceed activations", BANK);

    longest_bound: assert property (@(posedge clk) disable iff (rst)
        longest_run <= act_cnt)
        else $error("bank %0d: longest run exceeds activations", BANK);

endmodule

//--- hw/sdram_cmd_decode.sv
// SDRAM command decoder
`include "sdram_stats_defines.svh"

module sdram_cmd_decode (
    input  logic                          clk,
    input  logic                          rst,
    input  logic [`SDRAM_AW-1:0]          sdram_a,
    input  logic [`SDRAM_BAW-1:0]         sdram_ba,
    input  logic                          sdram_ncs,
    input  logic                          sdram_nras,
    input  logic                          sdram_ncas,
    input  logic                          sdram_nwe,
    output logic                          ev_act,    // One cycle per ACTIVE
    output logic                          ev_read,   // One cycle per READ
    output logic                          ev_write,  // One cycle per WRITE
    output logic [`SDRAM_BAW-1:0]         ev_ba,
    output sdram_stats_pkg::sdram_addr_u  ev_addr
);

    logic [3:0]              pins_q;  // {cs_n, ras_n, cas_n, we_n} as sampled
    logic [`SDRAM_BAW-1:0]   ba_q;
    logic [`SDRAM_AW-1:0]    a_q;
    sdram_stats_pkg::sdram_cmd_e cmd;

    // Control pins idle as deselected out of reset
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pins_q <= 4'b1111;
        end else begin
            pins_q <= {sdram_ncs, sdram_nras, sdram_ncas, sdram_nwe};
        end
    end

    // Bank and address samples travel alongside
    always_ff @(posedge clk) begin
        ba_q <= sdram_ba;
        a_q  <= sdram_a;
    end

    // cs_n high masks the rest of the word
    always_comb begin
        if (pins_q[3]) begin
            cmd = sdram_stats_pkg::CMD_INHIBIT;
        end else begin
            cmd = sdram_stats_pkg::sdram_cmd_e'(pins_q);
        end
    end

    // Strobes only for the commands the banks count
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ev_act   <= 1'b0;
            ev_read  <= 1'b0;
            ev_write <= 1'b0;
        end else begin
            ev_act   <= (cmd == sdram_stats_pkg::CMD_ACTIVE);
            ev_read  <= (cmd == sdram_stats_pkg::CMD_READ);
            ev_write <= (cmd == sdram_stats_pkg::CMD_WRITE);
        end
    end

    always_ff @(posedge clk) begin
        ev_ba       <= ba_q;
        ev_addr.row <= a_q;  // Raw word; banks pick the view
    end

    // Banks rely on a single event per cycle
    strobe_onehot: assert property (@(posedge clk) disable iff (rst)
        $onehot0({ev_act, ev_read, ev_write}))
        else $error("decoder raised more than one event strobe");

endmodule

//--- hw/sdram_stats_pkg.sv
// SDRAM statistics monitor types
`include "sdram_stats_defines.svh"

package sdram_stats_pkg;

    // Command word as {cs_n, ras_n, cas_n, we_n}
    typedef enum logic [3:0] {
        CMD_LOAD_MODE  = 4'b0000,
        CMD_REFRESH    = 4'b0001,
        CMD_PRECHARGE  = 4'b0010,
        CMD_ACTIVE     = 4'b0011,
        CMD_WRITE      = 4'b0100,
        CMD_READ       = 4'b0101,
        CMD_BURST_STOP = 4'b0110,
        CMD_NOP        = 4'b0111,
        CMD_INHIBIT    = 4'b1000   // Stands for every code with cs_n high
    } sdram_cmd_e;

    // Column view of the address during READ/WRITE
    typedef struct packed {
        logic [1:0] upper;   // A12..A11, unused by the column
        logic       ap;      // A10, auto-precharge
        logic [9:0] column;  // A9..A0
    } sdram_col_t;

    // Same pins with two meanings depending on the command
    typedef union packed {
        logic [`SDRAM_AW-1:0] row;  // ACTIVE
        sdram_col_t           col;  // READ / WRITE
    } sdram_addr_u;

    // Saturating statistics counter
    typedef logic [`STAT_W-1:0] stat_t;

endpackage

//--- hw/sdram_stats_defines.svh
// SDRAM statistics monitor constants
`ifndef SDRAM_STATS_DEFINES_SVH
`define SDRAM_STATS_DEFINES_SVH

// Bus geometry
`define SDRAM_AW     13   // Address pins A12..A0
`define SDRAM_BANKS  4    // Banks tracked
`define SDRAM_BAW    2    // Bank address width

// Counter width
`define STAT_W       32

// Readout field codes
`define FLD_W        3
`define FLD_ACT      3'd0  // Activations
`define FLD_SAMEROW  3'd1  // Reopened the last row
`define FLD_LONGEST  3'd2  // Longest same-row run
`define FLD_READ     3'd3
`define FLD_WRITE    3'd4
`define FLD_AUTOPRE  3'd5  // Read/write with A10 set
`define FLD_TOTAL    3'd6  // Sum of activations over all banks
// Code 7 is unassigned and reads as zero

`endif
